// ==== all.f ====
verilog/rvCorePkg.sv
verilog/rvDecoder.sv
verilog/rvAlu.sv
verilog/rvRegFile.sv
verilog/rvHazard.sv
verilog/rvLoadStore.sv
verilog/rvCpuTop.sv
bench/rvCpu_checker.sv
bench/rvCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rvCpuTb \
   -f all.f --Mdir obj_dir -o rvCpuSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/rvCpuSim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0

// ==== bench/rvCpuTb.sv ====
//**************************************************************************
// Testbench for the three stage RV32I core
// Loads a program through the host port, starts the core, returns I/O
// credits after random delays and compares every I/O word in order
//**************************************************************************
`timescale 1ns/1ps

module rvCpuTb;

   import rvCorePkg::*;

   localparam int imemWords   = 256;
   localparam int dmemWords   = 256;
   localparam int ioCredits   = 2;
   localparam int progLen     = 53;
   localparam int expLen      = 18;
   localparam int holdCycles  = 30;
   localparam int maxDelay    = 6;
   localparam int limitCycles = progLen * 40 + expLen * (8 + maxDelay) + holdCycles;

   // Expected I/O words as {port, data} in program order
   localparam logic [35:0] expWords [expLen] = '{
      {4'd0, 32'hFFFF_FFEC}, {4'd0, 32'hFFFF_FFFB}, {4'd0, 32'h0000_0001},
      {4'd0, 32'h0000_0019}, {4'd0, 32'hFFFF_FFFF}, {4'd0, 32'h0000_05F5},
      {4'd0, 32'h1234_5678}, {4'd0, 32'h0000_1048}, {4'd0, 32'hFFEC_8078},
      {4'd0, 32'hFFFF_FF81}, {4'd0, 32'h0000_0080}, {4'd0, 32'hFFFF_FFEC},
      {4'd0, 32'h0000_FFEC}, {4'd1, 32'h0000_0005}, {4'd1, 32'h0000_00A0},
      {4'd1, 32'h0000_00B0}, {4'd1, 32'hFFFF_FFEC}, {4'd2, 32'h0000_0000}
   };

   logic        clk;
   logic        rst;
   logic        run;
   progWrite_t  prog;
   ioTx_t       ioTx;
   logic        ioCreditReturn;
   logic [31:0] progWords [progLen];
   int          received = 0;
   int          returned = 0;

   rvCpuTop #(.imemWords(imemWords), .dmemWords(dmemWords), .ioCredits(ioCredits)) i_rvCpuTop
      (.clk(clk), .rst(rst), .run(run), .prog(prog), .ioTx(ioTx),
       .ioCreditReturn(ioCreditReturn));

   bind rvLoadStore ioCreditChecker #(.ioCredits(ioCredits)) i_ioCreditChecker
      (.clk(clk), .rst(rst), .valid(ioTx.valid), .creditCount(creditCount));

   // RV32I instruction formats
   function automatic logic [31:0] encodeR(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opOp};
   endfunction

   function automatic logic [31:0] encodeI(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction

   function automatic logic [31:0] encodeS(input int imm, input int rs2, input int rs1,
                                           input int f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
   endfunction

   function automatic logic [31:0] encodeB(input int imm, input int rs2, input int rs1,
                                           input int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
   endfunction

   function automatic logic [31:0] encodeU(input int imm, input int rd, input logic [6:0] op);
      return {imm[19:0], rd[4:0], op};
   endfunction

   function automatic logic [31:0] encodeJ(input int imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
   endfunction

   // x31 holds the I/O base and port 3 only ever sees squashed stores
   task automatic loadProgramTable();
      progWords[0]  = encodeU('h80000, 31, opLui);
      progWords[1]  = encodeI(-20, 0, 0, 1, opOpImm);
      progWords[2]  = encodeS(0, 1, 31, 2);
      progWords[3]  = encodeI('h402, 1, 5, 2, opOpImm);    // srai by 2
      progWords[4]  = encodeS(0, 2, 31, 2);
      progWords[5]  = encodeI(5, 0, 0, 4, opOpImm);
      progWords[6]  = encodeR(0, 1, 4, 3, 5);              // sltu
      progWords[7]  = encodeS(0, 5, 31, 2);
      progWords[8]  = encodeR('h20, 1, 4, 0, 7);           // sub
      progWords[9]  = encodeS(0, 7, 31, 2);
      progWords[10] = encodeR('h20, 4, 1, 5, 8);           // sra by x4
      progWords[11] = encodeS(0, 8, 31, 2);
      progWords[12] = encodeI(8, 4, 1, 10, opOpImm);
      progWords[13] = encodeI('h0F5, 10, 4, 10, opOpImm);
      progWords[14] = encodeS(0, 10, 31, 2);
      progWords[15] = encodeU('h12345, 11, opLui);
      progWords[16] = encodeI('h678, 11, 0, 11, opOpImm);
      progWords[17] = encodeS(0, 11, 31, 2);
      progWords[18] = encodeU(1, 12, opAuipc);
      progWords[19] = encodeS(0, 12, 31, 2);
      // Word at 0x40 then a byte and a halfword over it
      progWords[20] = encodeS(64, 11, 0, 2);
      progWords[21] = encodeI(-128, 0, 0, 13, opOpImm);
      progWords[22] = encodeS(65, 13, 0, 0);
      progWords[23] = encodeS(66, 1, 0, 1);
      progWords[24] = encodeI(64, 0, 2, 15, opLoad);
      progWords[25] = encodeS(0, 15, 31, 2);
      progWords[26] = encodeI(65, 0, 0, 16, opLoad);
      progWords[27] = encodeI(1, 16, 0, 16, opOpImm);
      progWords[28] = encodeS(0, 16, 31, 2);
      progWords[29] = encodeI(65, 0, 4, 17, opLoad);
      progWords[30] = encodeS(0, 17, 31, 2);
      progWords[31] = encodeI(66, 0, 1, 18, opLoad);
      progWords[32] = encodeS(0, 18, 31, 2);
      progWords[33] = encodeI(66, 0, 5, 19, opLoad);
      progWords[34] = encodeS(0, 19, 31, 2);
      // Control flow with its results on port 1
      progWords[35] = encodeB(8, 4, 4, 0);                 // beq taken
      progWords[36] = encodeS(12, 4, 31, 2);
      progWords[37] = encodeB(8, 4, 4, 1);                 // bne not taken
      progWords[38] = encodeS(4, 4, 31, 2);
      progWords[39] = encodeJ(8, 21);
      progWords[40] = encodeS(12, 4, 31, 2);
      progWords[41] = encodeS(4, 21, 31, 2);
      progWords[42] = encodeI('hB5, 0, 0, 22, opOpImm);
      progWords[43] = encodeI(0, 22, 0, 23, opJalr);       // lands on 0xB4
      progWords[44] = encodeS(12, 4, 31, 2);
      progWords[45] = encodeS(4, 23, 31, 2);
      progWords[46] = encodeB(8, 4, 1, 4);                 // blt taken
      progWords[47] = encodeS(12, 4, 31, 2);
      progWords[48] = encodeB(8, 4, 1, 5);                 // bge not taken
      progWords[49] = encodeS(4, 1, 31, 2);
      progWords[50] = encodeI(8, 31, 2, 24, opLoad);       // I/O load reads zero
      progWords[51] = encodeS(8, 24, 31, 2);
      progWords[52] = encodeJ(0, 0);
   endtask

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "Run stopped on the first error");
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      if (got !== want)
         failRun($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                           $time, name, got, want));
   endtask

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      void'($urandom(32'h38cbd48a));
      rst  = 1'b1;
      run  = 1'b0;
      prog = '0;
      loadProgramTable();
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // Idle core sends nothing
      repeat (10)
      begin
         @(negedge clk);
         checkValue("ioTx.valid", 32'(ioTx.valid), 32'd0);
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < progLen; i++)
      begin
         prog.we   = 1'b1;
         prog.addr = 12'(i);
         prog.data = progWords[i];
         @(posedge clk);
         #1;
      end
      prog = '0;
      run  = 1'b1;
      wait (received == expLen);
      // Quiet time in the final loop so a stray word would still show up
      repeat (20) @(posedge clk);
      $display("TESTS PASSED");
      $finish;
   end

   // Sink returns one credit per received word
   initial
   begin
      int delay;
      ioCreditReturn = 1'b0;
      wait (run === 1'b1);
      repeat (holdCycles) @(posedge clk);
      #1;
      checkValue("words during credit hold", 32'(received), 32'(ioCredits));
      forever
      begin
         if (returned < received)
         begin
            delay = int'($urandom % (maxDelay + 1));
            repeat (delay)
            begin
               @(posedge clk);
               #1;
            end
            ioCreditReturn = 1'b1;
            @(posedge clk);
            #1;
            ioCreditReturn = 1'b0;
            returned++;
         end
         else
         begin
            @(posedge clk);
            #1;
         end
      end
   end

   always @(negedge clk)
   begin
      if (ioTx.valid === 1'b1)
      begin
         if (received >= expLen)
            failRun("An I/O word arrived beyond the expected table");
         else
         begin
            checkValue("ioTx.port", 32'(ioTx.port), 32'(expWords[received][35:32]));
            checkValue("ioTx.data", ioTx.data, expWords[received][31:0]);
            received++;
         end
      end
   end

   initial
   begin
      repeat (limitCycles) @(posedge clk);
      failRun("Timeout: not all expected I/O words arrived in time");
   end

endmodule

// ==== bench/rvCpu_checker.sv ====
//**************************************************************************
// I/O credit protocol checker
// Bound into the load and store unit, watches the credit counter and
// the outgoing word strobe
//**************************************************************************
`timescale 1ns/1ps

module ioCreditChecker
   #(parameter int ioCredits = 2)
   (input logic                             clk,
    input logic                             rst,
    input logic                             valid,
    input logic [$clog2(ioCredits + 1)-1:0] creditCount);

   // A word leaves only if a credit was held the cycle before
   sendHadCredit: assert property (@(posedge clk) disable iff (rst)
      valid |-> $past(creditCount) != '0)
      else $error("I/O word sent while no credit was left");

   creditBounded: assert property (@(posedge clk) disable iff (rst)
      creditCount <= ioCredits)
      else $error("I/O credit counter above its initial value");

   // Strobe is cleared by reset
   idleAfterReset: assert property (@(posedge clk)
      $past(rst) |-> !valid)
      else $error("I/O strobe high in the cycle after reset");

endmodule

// ==== verilog/rvCpuTop.sv ====
//**************************************************************************
// Three stage RV32I core
// Fetch, execute and writeback with writeback forwarding, on-chip
// instruction and data memory, a host program port and an I/O port
//**************************************************************************
`timescale 1ns/1ps

module rvCpuTop
   #(parameter int imemWords = 256,
     parameter int dmemWords = 256,
     parameter int ioCredits = 2)
   (input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,
    input  rvCorePkg::progWrite_t prog,
    output rvCorePkg::ioTx_t      ioTx,
    input  logic                  ioCreditReturn);

   import rvCorePkg::*;

   localparam int imemAw = $clog2(imemWords);

   logic [31:0] imem [imemWords];
   logic [31:0] pc;
   logic [31:0] nextPc;
   logic [31:0] imemOut;
   logic [31:0] exeInst;
   logic [31:0] exePc;
   logic        exeNop;
   ctrl_t       ctrl;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [31:0] rd1;
   logic [31:0] rd2;
   logic [31:0] rs1Val;
   logic [31:0] rs2Val;
   logic [31:0] aluA;
   logic [31:0] aluB;
   logic [31:0] aluResult;
   logic        taken;
   logic        redirect;
   logic [31:0] target;
   logic        fwdA;
   logic        fwdB;
   logic        squash;
   logic        stall;
   logic        ioBlocked;
   logic [31:0] loadData;
   wbReg_t      wb;
   logic [31:0] wbValue;

   // Host loads the program while the core is idle
   always_ff @(posedge clk)
   begin
      if (prog.we && !run)
         imem[prog.addr[imemAw-1:0]] <= prog.data;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         imemOut <= imem[pc[imemAw+1:2]];
         exePc   <= pc;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || !run)
      begin
         pc     <= 32'd0;
         exeNop <= 1'b1;
      end
      else if (!stall)
      begin
         pc     <= nextPc;
         exeNop <= squash;
      end
   end

   assign exeInst = exeNop ? nopInst : imemOut;

   rvDecoder i_rvDecoder (.inst(exeInst), .ctrl(ctrl), .rs1(rs1), .rs2(rs2));

   rvRegFile i_rvRegFile
      (.clk(clk), .ra1(rs1), .ra2(rs2), .wa(wb.rd), .we(wb.regWrite),
       .wd(wbValue), .rd1(rd1), .rd2(rd2));

   assign rs1Val = fwdA ? wbValue : rd1;
   assign rs2Val = fwdB ? wbValue : rd2;
   assign aluA   = (ctrl.aluSrcA == srcPc) ? exePc :
                   (ctrl.aluSrcA == srcZero) ? 32'd0 : rs1Val;
   assign aluB   = ctrl.aluSrcB ? ctrl.imm : rs2Val;

   rvAlu i_rvAlu
      (.a(aluA), .b(aluB), .op(ctrl.aluOp), .funct3(ctrl.funct3),
       .result(aluResult), .taken(taken));

   // JALR target has bit 0 cleared
   assign redirect = ctrl.isJal || ctrl.isJalr || (ctrl.isBranch && taken);
   assign target   = ctrl.isJalr ? {aluResult[31:1], 1'b0} : exePc + ctrl.imm;
   assign nextPc   = redirect ? target : pc + 32'd4;

   rvHazard i_rvHazard
      (.rs1(rs1), .rs2(rs2), .wbRd(wb.rd), .wbWrite(wb.regWrite),
       .redirect(redirect), .ioBlocked(ioBlocked), .fwdA(fwdA), .fwdB(fwdB),
       .squash(squash), .stall(stall));

   rvLoadStore #(.dmemWords(dmemWords), .ioCredits(ioCredits)) i_rvLoadStore
      (.clk(clk), .rst(rst), .addr(aluResult), .storeData(rs2Val),
       .memRead(ctrl.memRead), .memWrite(ctrl.memWrite), .funct3(ctrl.funct3),
       .hold(stall), .loadData(loadData), .ioBlocked(ioBlocked), .ioTx(ioTx),
       .ioCreditReturn(ioCreditReturn));

   // Stalled store leaves a bubble behind
   always_ff @(posedge clk)
   begin
      if (rst || stall)
      begin
         wb.regWrite <= 1'b0;
         wb.memRead  <= 1'b0;
      end
      else
      begin
         wb.regWrite <= ctrl.regWrite;
         wb.memRead  <= ctrl.memRead;
         wb.wbSel    <= ctrl.wbSel;
         wb.funct3   <= ctrl.funct3;
         wb.addrLo   <= aluResult[1:0];
         wb.rd       <= ctrl.rd;
         wb.result   <= aluResult;
         wb.link     <= exePc + 32'd4;
      end
   end

   always_comb
   begin
      case (wb.wbSel)
         wbLoad:  wbValue = loadData;
         wbLink:  wbValue = wb.link;
         default: wbValue = wb.result;
      endcase
   end

endmodule

// ==== verilog/rvLoadStore.sv ====
//**************************************************************************
// Load and store unit
// Data memory with byte enables, load alignment and extension in the
// writeback cycle, and the credit-controlled I/O output port
//**************************************************************************
`timescale 1ns/1ps

module rvLoadStore
   #(parameter int dmemWords = 256,
     parameter int ioCredits = 2)
   (input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      addr,
    input  logic [31:0]      storeData,
    input  logic             memRead,
    input  logic             memWrite,
    input  logic [2:0]       funct3,
    input  logic             hold,
    output logic [31:0]      loadData,
    output logic             ioBlocked,
    output rvCorePkg::ioTx_t ioTx,
    input  logic             ioCreditReturn);

   import rvCorePkg::*;

   localparam int aw = $clog2(dmemWords);
   localparam int cw = $clog2(ioCredits + 1);

   logic [31:0]   mem [dmemWords];
   logic [aw-1:0] wordIdx;
   logic          isIo;
   logic          ioStore;
   logic          send;
   logic [3:0]    byteEn;
   logic [31:0]   wrData;
   logic [31:0]   rdWord;
   logic [31:0]   shifted;
   logic [1:0]    loadLo;
   logic [2:0]    loadF3;
   logic          loadIo;
   logic [cw-1:0] creditCount;

   assign wordIdx   = addr[aw+1:2];
   assign isIo      = (addr & ioBase) != 32'd0;
   assign ioStore   = memWrite && isIo;
   assign ioBlocked = ioStore && (creditCount == '0);
   assign send      = ioStore && !hold && (creditCount != '0);

   // Lane placement for sb, sh and sw
   always_comb
   begin
      case (funct3[1:0])
         2'b00:
         begin
            byteEn = 4'b0001 << addr[1:0];
            wrData = {4{storeData[7:0]}};
         end
         2'b01:
         begin
            byteEn = 4'b0011 << {addr[1], 1'b0};
            wrData = {2{storeData[15:0]}};
         end
         default:
         begin
            byteEn = 4'b1111;
            wrData = storeData;
         end
      endcase
      if (!memWrite || isIo || hold)
         byteEn = 4'b0000;
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 4; i++)
      begin
         if (byteEn[i])
            mem[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
      end
      if (memRead && !hold)
      begin
         rdWord <= mem[wordIdx];
         loadLo <= addr[1:0];
         loadF3 <= funct3;
         loadIo <= isIo;
      end
   end

   // Alignment and extension happen in writeback
   assign shifted = rdWord >> {loadLo, 3'b000};

   always_comb
   begin
      case (loadF3)
         3'b000:  loadData = {{24{shifted[7]}}, shifted[7:0]};
         3'b001:  loadData = {{16{shifted[15]}}, shifted[15:0]};
         3'b100:  loadData = {24'd0, shifted[7:0]};
         3'b101:  loadData = {16'd0, shifted[15:0]};
         default: loadData = rdWord;
      endcase
      if (loadIo)
         loadData = 32'd0;
   end

   // Send and return in one cycle leave the count unchanged
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         creditCount <= cw'(ioCredits);
         ioTx.valid  <= 1'b0;
      end
      else
      begin
         if (send && !ioCreditReturn)
            creditCount <= creditCount - 1'b1;
         else if (!send && ioCreditReturn)
            creditCount <= creditCount + 1'b1;
         ioTx.valid <= send;
         ioTx.port  <= addr[5:2];
         ioTx.data  <= storeData;
      end
   end

endmodule

// ==== verilog/rvHazard.sv ====
//**************************************************************************
// Pipeline hazard control
// Writeback to execute forwarding, squash of the fetch behind a redirect,
// and the stall while an I/O store waits for a credit
//**************************************************************************
`timescale 1ns/1ps

module rvHazard
   (input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] wbRd,
    input  logic       wbWrite,
    input  logic       redirect,
    input  logic       ioBlocked,
    output logic       fwdA,
    output logic       fwdB,
    output logic       squash,
    output logic       stall);

   logic wbLive;

   // x0 writes never forward
   assign wbLive = wbWrite && (wbRd != 5'd0);

   assign fwdA = wbLive && (wbRd == rs1);
   assign fwdB = wbLive && (wbRd == rs2);

   // Whole front end holds until a credit returns
   assign stall = ioBlocked;

   // A held instruction cannot redirect yet
   assign squash = redirect && !stall;

endmodule

// ==== verilog/rvRegFile.sv ====
//**************************************************************************
// Integer register file
// 32 registers, two combinational reads, one write per clock, x0 is zero
//**************************************************************************
`timescale 1ns/1ps

module rvRegFile
   (input  logic        clk,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2);

   logic [31:0] regs [32];

   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// ==== verilog/rvAlu.sv ====
//**************************************************************************
// RV32I ALU
// Arithmetic and logic result plus the branch condition of a against b
//**************************************************************************
`timescale 1ns/1ps

module rvAlu
   (input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  rvCorePkg::aluOp_t op,
    input  logic [2:0]       funct3,
    output logic [31:0]      result,
    output logic             taken);

   import rvCorePkg::*;

   always_comb
   begin
      case (op)
         aluAdd:  result = a + b;
         aluSub:  result = a - b;
         aluSll:  result = a << b[4:0];
         aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
         aluSltu: result = {31'b0, a < b};
         aluXor:  result = a ^ b;
         aluSrl:  result = a >> b[4:0];
         aluSra:  result = $unsigned($signed(a) >>> b[4:0]);
         aluOr:   result = a | b;
         aluAnd:  result = a & b;
         default: result = b;
      endcase
   end

   // Branch compare, valid only when the decoder flags a branch
   always_comb
   begin
      case (funct3)
         3'b000:  taken = (a == b);
         3'b001:  taken = (a != b);
         3'b100:  taken = $signed(a) < $signed(b);
         3'b101:  taken = $signed(a) >= $signed(b);
         3'b110:  taken = a < b;
         3'b111:  taken = a >= b;
         default: taken = 1'b0;
      endcase
   end

endmodule

// ==== verilog/rvDecoder.sv ====
//**************************************************************************
// RV32I instruction decoder
// Splits the instruction word, builds the immediate and produces the
// control bundle for the execute stage
//**************************************************************************
`timescale 1ns/1ps

module rvDecoder
   (input  logic [31:0]     inst,
    output rvCorePkg::ctrl_t ctrl,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2);

   import rvCorePkg::*;

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [31:0] immI;
   logic [31:0] immS;
   logic [31:0] immB;
   logic [31:0] immU;
   logic [31:0] immJ;
   aluOp_t      arithOp;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];
   assign rs1    = inst[19:15];
   assign rs2    = inst[24:20];

   assign immI = {{20{inst[31]}}, inst[31:20]};
   assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign immU = {inst[31:12], 12'b0};
   assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   // Shared by register and immediate arithmetic
   always_comb
   begin
      case (funct3)
         3'b000:  arithOp = (opcode == opOp && funct7[5]) ? aluSub : aluAdd;
         3'b001:  arithOp = aluSll;
         3'b010:  arithOp = aluSlt;
         3'b011:  arithOp = aluSltu;
         3'b100:  arithOp = aluXor;
         3'b101:  arithOp = funct7[5] ? aluSra : aluSrl;
         3'b110:  arithOp = aluOr;
         default: arithOp = aluAnd;
      endcase
   end

   always_comb
   begin
      ctrl         = '0;
      ctrl.aluOp   = aluAdd;
      ctrl.aluSrcA = srcReg;
      ctrl.wbSel   = wbAlu;
      ctrl.funct3  = funct3;
      ctrl.rd      = inst[11:7];
      ctrl.imm     = immI;
      case (opcode)
         opOp:
         begin
            ctrl.aluOp    = arithOp;
            ctrl.regWrite = 1'b1;
         end
         opOpImm:
         begin
            ctrl.aluOp    = arithOp;
            ctrl.aluSrcB  = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         opLui, opAuipc:
         begin
            ctrl.aluSrcA  = (opcode == opLui) ? srcZero : srcPc;
            ctrl.aluSrcB  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.imm      = immU;
         end
         opJal, opJalr:
         begin
            ctrl.isJal    = (opcode == opJal);
            ctrl.isJalr   = (opcode == opJalr);
            ctrl.aluSrcB  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel    = wbLink;
            ctrl.imm      = (opcode == opJal) ? immJ : immI;
         end
         opBranch:
         begin
            ctrl.aluOp    = aluSub;
            ctrl.isBranch = 1'b1;
            ctrl.imm      = immB;
         end
         opLoad:
         begin
            ctrl.aluSrcB  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel    = wbLoad;
            ctrl.memRead  = 1'b1;
         end
         opStore:
         begin
            ctrl.aluSrcB  = 1'b1;
            ctrl.memWrite = 1'b1;
            ctrl.imm      = immS;
         end
         // Unknown opcodes behave as a NOP
         default: ctrl.aluOp = aluPassB;
      endcase
   end

endmodule

// ==== verilog/rvCorePkg.sv ====
//**************************************************************************
// RV32I core definitions
// Opcodes, ALU and writeback encodings, and the packed bundles that
// travel between the decoder, the pipeline registers and the ports
//**************************************************************************

package rvCorePkg;

   localparam logic [6:0] opOp     = 7'b0110011;
   localparam logic [6:0] opOpImm  = 7'b0010011;
   localparam logic [6:0] opLui    = 7'b0110111;
   localparam logic [6:0] opAuipc  = 7'b0010111;
   localparam logic [6:0] opJal    = 7'b1101111;
   localparam logic [6:0] opJalr   = 7'b1100111;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;

   // addi x0, x0, 0
   localparam logic [31:0] nopInst = 32'h0000_0013;

   // Address bit 31 selects the I/O region
   localparam logic [31:0] ioBase = 32'h8000_0000;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
      aluSrl, aluSra, aluOr, aluAnd, aluPassB
   } aluOp_t;

   typedef enum logic [1:0] {wbAlu, wbLoad, wbLink} wbSel_t;

   typedef enum logic [1:0] {srcReg, srcPc, srcZero} srcA_t;

   typedef struct packed {
      aluOp_t      aluOp;
      srcA_t       aluSrcA;
      logic        aluSrcB;   // 1 selects the immediate
      logic        regWrite;
      wbSel_t      wbSel;
      logic        isBranch;
      logic        isJal;
      logic        isJalr;
      logic        memRead;
      logic        memWrite;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [31:0] imm;
   } ctrl_t;

   typedef struct packed {
      logic        regWrite;
      wbSel_t      wbSel;
      logic        memRead;
      logic [2:0]  funct3;
      logic [1:0]  addrLo;
      logic [4:0]  rd;
      logic [31:0] result;
      logic [31:0] link;
   } wbReg_t;

   typedef struct packed {
      logic        we;
      logic [11:0] addr;   // word address
      logic [31:0] data;
   } progWrite_t;

   typedef struct packed {
      logic        valid;
      logic [3:0]  port;
      logic [31:0] data;
   } ioTx_t;

endpackage
